//--- source/rvPipePkg.sv
package rvPipePkg;

    typedef logic [31:0] word_t;      // Data and address word
    typedef logic [4:0]  regAddr_t;
    typedef logic [7:0]  btbIdx_t;    // Wide enough for any target buffer size
    typedef logic [7:0]  phtIdx_t;

    typedef enum logic [2:0] {immI, immS, immB, immJ, immU} immSel_e;
    typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluOr, aluSlt} aluOp_e;
    typedef enum logic [1:0] {resAlu, resMem, resPcPlus4, resImm} resultSel_e;
    typedef enum logic [1:0] {fwdRegFile, fwdFromMem, fwdFromWb} fwdSel_e;

    // Major opcodes
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opOp     = 7'b0110011;
    localparam logic [6:0] opImm    = 7'b0010011;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opLui    = 7'b0110111;

    localparam logic [2:0] f3Beq    = 3'b000;
    localparam logic [2:0] f3Bne    = 3'b001;
    localparam logic [2:0] f3Word   = 3'b010;   // lw and sw
    localparam logic [2:0] f3AddSub = 3'b000;
    localparam logic [2:0] f3Slt    = 3'b010;
    localparam logic [2:0] f3Or     = 3'b110;
    localparam logic [2:0] f3And    = 3'b111;

    typedef struct packed {
        logic       regWrite;
        logic       memWrite;
        resultSel_e resultSel;
        aluOp_e     aluOp;
        logic       aluSrcImm;
        immSel_e    immSel;
        logic       branch;
        logic       branchNe;
        logic       jump;
    } ctrl_t;

    typedef struct packed {
        regAddr_t rs1D;
        regAddr_t rs2D;
        regAddr_t rs1E;
        regAddr_t rs2E;
        regAddr_t rdE;
        logic     loadE;
        regAddr_t rdM;
        logic     regWriteM;
        regAddr_t rdW;
        logic     regWriteW;
        logic     mispredictE;
    } hazardIn_t;

    typedef struct packed {
        logic    stallF;
        logic    stallD;
        logic    flushD;
        logic    flushE;
        fwdSel_e fwdA;
        fwdSel_e fwdB;
    } hazardCtrl_t;

    typedef struct packed {
        logic    btbWe;
        btbIdx_t btbIdx;
        word_t   btbTag;      // PC above the index bits, right aligned
        word_t   btbTarget;
        logic    isJump;
        logic    phtWe;
        phtIdx_t phtIdx;
        logic    taken;
        logic    historyReset;
    } predUpdate_t;

endpackage

//--- source/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder import rvPipePkg::*; (
    input  word_t instr_i,
    output ctrl_t ctrl_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       funct7b5;
    logic       aluValid;
    aluOp_e     aluOp;

    assign opcode   = instr_i[6:0];
    assign funct3   = instr_i[14:12];
    assign funct7b5 = instr_i[30];

    // ALU decode shared by op and op-imm
    always_comb begin
        aluValid = 1'b1;
        case (funct3)
            f3AddSub: aluOp = (funct7b5 && opcode == opOp) ? aluSub : aluAdd;
            f3Slt:    aluOp = aluSlt;
            f3Or:     aluOp = aluOr;
            f3And:    aluOp = aluAnd;
            default: begin
                aluOp    = aluAdd;
                aluValid = 1'b0;
            end
        endcase
    end

    always_comb begin
        ctrl_o = '0;    // Bubble unless recognized
        case (opcode)
            opImm: if (aluValid) begin
                ctrl_o.regWrite  = 1'b1;
                ctrl_o.aluOp     = aluOp;
                ctrl_o.aluSrcImm = 1'b1;
            end
            opOp: if (aluValid) begin
                ctrl_o.regWrite = 1'b1;
                ctrl_o.aluOp    = aluOp;
            end
            opLoad: if (funct3 == f3Word) begin
                ctrl_o.regWrite  = 1'b1;
                ctrl_o.resultSel = resMem;
                ctrl_o.aluSrcImm = 1'b1;
            end
            opStore: if (funct3 == f3Word) begin
                ctrl_o.memWrite  = 1'b1;
                ctrl_o.aluSrcImm = 1'b1;
                ctrl_o.immSel    = immS;
            end
            opBranch: if (funct3 == f3Beq || funct3 == f3Bne) begin
                ctrl_o.branch   = 1'b1;
                ctrl_o.branchNe = (funct3 == f3Bne);
                ctrl_o.immSel   = immB;
            end
            opJal: begin
                ctrl_o.regWrite  = 1'b1;
                ctrl_o.resultSel = resPcPlus4;   // Link value
                ctrl_o.jump      = 1'b1;
                ctrl_o.immSel    = immJ;
            end
            opLui: begin
                ctrl_o.regWrite  = 1'b1;
                ctrl_o.resultSel = resImm;
                ctrl_o.immSel    = immU;
            end
            default: ;
        endcase
    end

endmodule

//--- source/regFile.sv
`timescale 1ns/1ps

module regFile import rvPipePkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  regAddr_t a1_i,
    input  regAddr_t a2_i,
    input  regAddr_t a3_i,
    input  logic     we3_i,
    input  word_t    wd3_i,
    output word_t    rd1_o,
    output word_t    rd2_o
);

    word_t regs [32];

    // Falling edge write, so decode sees writeback in the same cycle
    always_ff @(negedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we3_i) begin
            regs[a3_i] <= wd3_i;
        end
    end

    assign rd1_o = (a1_i == '0) ? '0 : regs[a1_i];   // x0 reads as zero
    assign rd2_o = (a2_i == '0) ? '0 : regs[a2_i];

endmodule

//--- source/branchPredictor.sv
`timescale 1ns/1ps

module branchPredictor import rvPipePkg::*; #(
    parameter int btbEntries = 32,
    parameter int ghrBits    = 3
) (
    input  logic               clk,
    input  logic               reset,
    input  word_t              pcF_i,
    output logic               predTaken_o,
    output word_t              predTarget_o,
    output logic [ghrBits-1:0] phtIdx_o,
    input  predUpdate_t        upd_i
);

    localparam int idxBits  = $clog2(btbEntries);
    localparam int tagBits  = 30 - idxBits;
    localparam int phtDepth = 2 ** ghrBits;

    logic               btbValid  [btbEntries];
    logic               btbJump   [btbEntries];
    logic [tagBits-1:0] btbTag    [btbEntries];
    word_t              btbTarget [btbEntries];
    logic [1:0]         pht       [phtDepth];
    logic [ghrBits-1:0] ghr;

    logic [idxBits-1:0] idxF;
    logic [idxBits-1:0] idxU;
    logic [tagBits-1:0] tagF;
    logic [ghrBits-1:0] phtU;
    logic               hitF;

    assign idxF = pcF_i[idxBits+1:2];
    assign tagF = pcF_i[31:idxBits+2];
    assign idxU = upd_i.btbIdx[idxBits-1:0];
    assign phtU = upd_i.phtIdx[ghrBits-1:0];
    assign hitF = btbValid[idxF] && (btbTag[idxF] == tagF);

    // Counter upper bit means 2 or 3
    assign predTaken_o  = hitF && (btbJump[idxF] || pht[ghr][1]);
    assign predTarget_o = btbTarget[idxF];
    assign phtIdx_o     = ghr;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < btbEntries; i++) begin
                btbValid[i] <= 1'b0;
                btbJump[i]  <= 1'b0;
            end
        end else if (upd_i.btbWe) begin
            btbValid[idxU] <= 1'b1;
            btbJump[idxU]  <= upd_i.isJump;
        end
    end

    always_ff @(posedge clk) begin
        if (upd_i.btbWe) begin
            btbTag[idxU]    <= upd_i.btbTag[tagBits-1:0];
            btbTarget[idxU] <= upd_i.btbTarget;
        end
    end

    // Saturating counters and outcome history
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < phtDepth; i++) begin
                pht[i] <= 2'b01;   // Weakly not taken
            end
            ghr <= '0;
        end else begin
            if (upd_i.phtWe) begin
                if (upd_i.taken && pht[phtU] != 2'b11) begin
                    pht[phtU] <= pht[phtU] + 2'd1;
                end else if (!upd_i.taken && pht[phtU] != 2'b00) begin
                    pht[phtU] <= pht[phtU] - 2'd1;
                end
            end
            if (upd_i.historyReset) begin
                ghr <= '0;
            end else if (upd_i.phtWe) begin
                ghr <= {ghr[ghrBits-2:0], upd_i.taken};
            end
        end
    end

    assert property (@(posedge clk) disable iff (reset) upd_i.btbWe |-> !$isunknown(upd_i.btbIdx))
        else $error("target buffer write with unknown index");

endmodule

//--- source/hazardUnit.sv
`timescale 1ns/1ps

module hazardUnit import rvPipePkg::*; (
    input  hazardIn_t   hazIn_i,
    output hazardCtrl_t hazCtrl_o
);

    logic loadUse;

    // Memory stage wins over writeback and x0 is never forwarded
    function automatic fwdSel_e pickFwd(input regAddr_t rs, input hazardIn_t h);
        if (rs != '0 && rs == h.rdM && h.regWriteM) begin
            return fwdFromMem;
        end else if (rs != '0 && rs == h.rdW && h.regWriteW) begin
            return fwdFromWb;
        end
        return fwdRegFile;
    endfunction

    always_comb begin
        loadUse = hazIn_i.loadE && hazIn_i.rdE != '0 &&
                  (hazIn_i.rdE == hazIn_i.rs1D || hazIn_i.rdE == hazIn_i.rs2D);

        hazCtrl_o.fwdA = pickFwd(hazIn_i.rs1E, hazIn_i);
        hazCtrl_o.fwdB = pickFwd(hazIn_i.rs2E, hazIn_i);

        // A redirect wins since the instruction waiting in decode is wrong path
        hazCtrl_o.stallF = loadUse && !hazIn_i.mispredictE;
        hazCtrl_o.stallD = loadUse && !hazIn_i.mispredictE;
        hazCtrl_o.flushD = hazIn_i.mispredictE;
        hazCtrl_o.flushE = loadUse || hazIn_i.mispredictE;

        // A load never redirects so a load-use stall never meets a redirect flush
        assert final (!(hazIn_i.loadE && hazIn_i.mispredictE))
            else $error("load in execute reported a misprediction");
    end

endmodule

//--- source/datapath.sv
`timescale 1ns/1ps

module datapath import rvPipePkg::*; #(
    parameter int    btbEntries = 32,
    parameter int    ghrBits    = 3,
    parameter word_t startPc    = '0
) (
    input  logic               clk,
    input  logic               reset,
    output word_t              pcF_o,
    input  word_t              instrF_i,
    output word_t              instrD_o,
    input  ctrl_t              ctrlD_i,
    output hazardIn_t          hazIn_o,
    input  hazardCtrl_t        hazCtrl_i,
    output regAddr_t           rs1D_o,
    output regAddr_t           rs2D_o,
    input  word_t              rd1D_i,
    input  word_t              rd2D_i,
    output regAddr_t           rdW_o,
    output logic               regWriteW_o,
    output word_t              resultW_o,
    input  logic               predTakenF_i,
    input  word_t              predTargetF_i,
    input  logic [ghrBits-1:0] phtIdxF_i,
    output predUpdate_t        predUpd_o,
    output logic               memWriteM_o,
    output word_t              aluResultM_o,
    output word_t              writeDataM_o,
    input  word_t              readDataM_i
);

    localparam int idxBits = $clog2(btbEntries);

    typedef struct packed {
        word_t              instr;
        word_t              pc;
        word_t              pcPlus4;
        word_t              predNext;   // Next PC that fetch chose
        logic [ghrBits-1:0] phtIdx;
    } decodeReg_t;

    typedef struct packed {
        ctrl_t              ctrl;
        word_t              pc;
        word_t              pcPlus4;
        word_t              predNext;
        logic [ghrBits-1:0] phtIdx;
        word_t              rd1;
        word_t              rd2;
        word_t              imm;
        regAddr_t           rs1;
        regAddr_t           rs2;
        regAddr_t           rd;
    } executeReg_t;

    // Memory and writeback registers, data is store data in M and load data in W
    typedef struct packed {
        ctrl_t    ctrl;
        word_t    result;
        word_t    data;
        regAddr_t rd;
    } lateReg_t;

    decodeReg_t  regD;
    executeReg_t regE;
    lateReg_t    regM;
    lateReg_t    regW;

    word_t pcPlus4F;
    word_t predNextF;
    word_t pcNextF;
    word_t instrD;
    word_t immD;
    word_t srcA;
    word_t srcB;
    word_t writeDataE;
    word_t aluOut;
    word_t resultE;
    word_t targetE;
    word_t actualNextE;
    word_t resultW;
    logic  equalE;
    logic  takenE;
    logic  redirectE;
    logic  mispredictE;

    function automatic word_t pickOperand(input fwdSel_e sel, input word_t rf,
                                          input word_t fromMem, input word_t fromWb);
        case (sel)
            fwdFromMem: return fromMem;
            fwdFromWb:  return fromWb;
            default:    return rf;
        endcase
    endfunction

    // Fetch
    assign pcPlus4F  = pcF_o + 32'd4;
    assign predNextF = predTakenF_i ? predTargetF_i : pcPlus4F;
    assign pcNextF   = mispredictE ? actualNextE : predNextF;

    always_ff @(posedge clk) begin
        if (reset) begin
            pcF_o <= startPc;
        end else if (!hazCtrl_i.stallF) begin
            pcF_o <= pcNextF;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || hazCtrl_i.flushD) begin
            regD <= '0;     // All-zero word decodes as a bubble
        end else if (!hazCtrl_i.stallD) begin
            regD.instr    <= instrF_i;
            regD.pc       <= pcF_o;
            regD.pcPlus4  <= pcPlus4F;
            regD.predNext <= predNextF;
            regD.phtIdx   <= phtIdxF_i;
        end
    end

    // Decode
    assign instrD   = regD.instr;
    assign instrD_o = instrD;
    assign rs1D_o   = instrD[19:15];
    assign rs2D_o   = instrD[24:20];

    always_comb begin
        case (ctrlD_i.immSel)
            immS:    immD = {{20{instrD[31]}}, instrD[31:25], instrD[11:7]};
            immB:    immD = {{20{instrD[31]}}, instrD[7], instrD[30:25], instrD[11:8], 1'b0};
            immJ:    immD = {{12{instrD[31]}}, instrD[19:12], instrD[20], instrD[30:21], 1'b0};
            immU:    immD = {instrD[31:12], 12'b0};
            default: immD = {{20{instrD[31]}}, instrD[31:20]};
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset || hazCtrl_i.flushE) begin
            regE <= '0;
        end else begin
            regE.ctrl     <= ctrlD_i;
            regE.pc       <= regD.pc;
            regE.pcPlus4  <= regD.pcPlus4;
            regE.predNext <= regD.predNext;
            regE.phtIdx   <= regD.phtIdx;
            regE.rd1      <= rd1D_i;
            regE.rd2      <= rd2D_i;
            regE.imm      <= immD;
            regE.rs1      <= rs1D_o;
            regE.rs2      <= rs2D_o;
            regE.rd       <= instrD[11:7];
        end
    end

    // Execute
    assign srcA       = pickOperand(hazCtrl_i.fwdA, regE.rd1, regM.result, resultW);
    assign writeDataE = pickOperand(hazCtrl_i.fwdB, regE.rd2, regM.result, resultW);
    assign srcB       = regE.ctrl.aluSrcImm ? regE.imm : writeDataE;

    always_comb begin
        case (regE.ctrl.aluOp)
            aluSub:  aluOut = srcA - srcB;
            aluAnd:  aluOut = srcA & srcB;
            aluOr:   aluOut = srcA | srcB;
            aluSlt:  aluOut = {31'b0, $signed(srcA) < $signed(srcB)};
            default: aluOut = srcA + srcB;
        endcase
    end

    // Link and lui values are settled here so forwarding needs one source
    always_comb begin
        case (regE.ctrl.resultSel)
            resPcPlus4: resultE = regE.pcPlus4;
            resImm:     resultE = regE.imm;
            default:    resultE = aluOut;   // Also the load and store address
        endcase
    end

    assign targetE     = regE.pc + regE.imm;
    assign equalE      = (srcA == writeDataE);
    assign takenE      = regE.ctrl.branch && (regE.ctrl.branchNe ? !equalE : equalE);
    assign redirectE   = takenE || regE.ctrl.jump;
    assign actualNextE = redirectE ? targetE : regE.pcPlus4;
    assign mispredictE = (regE.ctrl.branch || regE.ctrl.jump) && (actualNextE != regE.predNext);

    always_comb begin
        predUpd_o.btbWe        = redirectE;
        predUpd_o.btbIdx       = btbIdx_t'(regE.pc[idxBits+1:2]);
        predUpd_o.btbTag       = regE.pc >> (idxBits + 2);
        predUpd_o.btbTarget    = targetE;
        predUpd_o.isJump       = regE.ctrl.jump;
        predUpd_o.phtWe        = regE.ctrl.branch;
        predUpd_o.phtIdx       = phtIdx_t'(regE.phtIdx);
        predUpd_o.taken        = takenE;
        predUpd_o.historyReset = regE.ctrl.branch && mispredictE;
    end

    // Memory
    always_ff @(posedge clk) begin
        if (reset) begin
            regM <= '0;
        end else begin
            regM.ctrl   <= regE.ctrl;
            regM.result <= resultE;
            regM.data   <= writeDataE;
            regM.rd     <= regE.rd;
        end
    end

    assign memWriteM_o  = regM.ctrl.memWrite;
    assign aluResultM_o = regM.result;
    assign writeDataM_o = regM.data;

    // Writeback
    always_ff @(posedge clk) begin
        if (reset) begin
            regW <= '0;
        end else begin
            regW.ctrl   <= regM.ctrl;
            regW.result <= regM.result;
            regW.data   <= readDataM_i;
            regW.rd     <= regM.rd;
        end
    end

    assign resultW     = (regW.ctrl.resultSel == resMem) ? regW.data : regW.result;
    assign resultW_o   = resultW;
    assign rdW_o       = regW.rd;
    assign regWriteW_o = regW.ctrl.regWrite;

    always_comb begin
        hazIn_o.rs1D        = rs1D_o;
        hazIn_o.rs2D        = rs2D_o;
        hazIn_o.rs1E        = regE.rs1;
        hazIn_o.rs2E        = regE.rs2;
        hazIn_o.rdE         = regE.rd;
        hazIn_o.loadE       = regE.ctrl.regWrite && (regE.ctrl.resultSel == resMem);
        hazIn_o.rdM         = regM.rd;
        hazIn_o.regWriteM   = regM.ctrl.regWrite;
        hazIn_o.rdW         = regW.rd;
        hazIn_o.regWriteW   = regW.ctrl.regWrite;
        hazIn_o.mispredictE = mispredictE;
    end

    assert property (@(posedge clk) disable iff (reset) !$isunknown(memWriteM_o))
        else $error("store strobe unknown");

endmodule

//--- source/rvPipeTop.sv
`timescale 1ns/1ps

module rvPipeTop import rvPipePkg::*; #(
    parameter int    btbEntries = 32,
    parameter int    ghrBits    = 3,
    parameter word_t startPc    = '0
) (
    input  logic  clk,
    input  logic  reset,
    output word_t pcF_o,
    input  word_t instrF_i,
    output logic  memWriteM_o,
    output word_t aluResultM_o,
    output word_t writeDataM_o,
    input  word_t readDataM_i
);

    word_t              instrD;
    ctrl_t              ctrlD;
    hazardIn_t          hazIn;
    hazardCtrl_t        hazCtrl;
    regAddr_t           rs1D;
    regAddr_t           rs2D;
    regAddr_t           rdW;
    word_t              rd1D;
    word_t              rd2D;
    word_t              resultW;
    logic               regWriteW;
    logic               predTakenF;
    word_t              predTargetF;
    logic [ghrBits-1:0] phtIdxF;
    predUpdate_t        predUpd;

    datapath #(
        .btbEntries(btbEntries),
        .ghrBits(ghrBits),
        .startPc(startPc)
    ) dpath (
        .clk(clk),
        .reset(reset),
        .pcF_o(pcF_o),
        .instrF_i(instrF_i),
        .instrD_o(instrD),
        .ctrlD_i(ctrlD),
        .hazIn_o(hazIn),
        .hazCtrl_i(hazCtrl),
        .rs1D_o(rs1D),
        .rs2D_o(rs2D),
        .rd1D_i(rd1D),
        .rd2D_i(rd2D),
        .rdW_o(rdW),
        .regWriteW_o(regWriteW),
        .resultW_o(resultW),
        .predTakenF_i(predTakenF),
        .predTargetF_i(predTargetF),
        .phtIdxF_i(phtIdxF),
        .predUpd_o(predUpd),
        .memWriteM_o(memWriteM_o),
        .aluResultM_o(aluResultM_o),
        .writeDataM_o(writeDataM_o),
        .readDataM_i(readDataM_i)
    );

    instrDecoder decoder (
        .instr_i(instrD),
        .ctrl_o(ctrlD)
    );

    hazardUnit hazards (
        .hazIn_i(hazIn),
        .hazCtrl_o(hazCtrl)
    );

    regFile regs (
        .clk(clk),
        .reset(reset),
        .a1_i(rs1D),
        .a2_i(rs2D),
        .a3_i(rdW),
        .we3_i(regWriteW),
        .wd3_i(resultW),
        .rd1_o(rd1D),
        .rd2_o(rd2D)
    );

    branchPredictor #(
        .btbEntries(btbEntries),
        .ghrBits(ghrBits)
    ) predictor (
        .clk(clk),
        .reset(reset),
        .pcF_i(pcF_o),
        .predTaken_o(predTakenF),
        .predTarget_o(predTargetF),
        .phtIdx_o(phtIdxF),
        .upd_i(predUpd)
    );

endmodule

//--- sim/clockGen.sv
`timescale 1ns/1ps

module clockGen #(
    parameter int resetCycles = 16
) (
    input  logic resetReq_i,
    output logic clk_o,
    output logic reset_o
);

    int holdLeft;

    initial begin
        clk_o    = 1'b0;
        reset_o  = 1'b1;
        holdLeft = resetCycles;
    end

    always #5 clk_o = ~clk_o;   // 10 ns period

    // Reset counts rising edges and moves just after the edge
    always @(posedge clk_o) begin
        if (resetReq_i) begin
            holdLeft = resetCycles;
            reset_o <= #1 1'b1;
        end else if (holdLeft > 0) begin
            holdLeft = holdLeft - 1;
            if (holdLeft == 0) begin
                reset_o <= #1 1'b0;
            end
        end
    end

endmodule

//--- sim/rvPipeTb.sv
`timescale 1ns/1ps

module rvPipeTb import rvPipePkg::*; ();

    localparam word_t startPc       = 32'h0000_0080;
    localparam int    timeoutCycles = 3000;
    localparam int    quietCycles   = 40;    // Window for stray stores

    logic  clk;
    logic  reset;
    logic  resetReq;
    word_t pcF;
    word_t instrF;
    logic  memWriteM;
    word_t aluResultM;
    word_t writeDataM;
    word_t readDataM;

    word_t imem [256];
    word_t dmem [256];
    word_t storeAddr [$];
    word_t storeData [$];
    word_t expAddr [$];
    word_t expData [$];
    word_t emitPc;
    word_t rngState;

    clockGen clkGen (
        .resetReq_i(resetReq),
        .clk_o(clk),
        .reset_o(reset)
    );

    rvPipeTop #(
        .btbEntries(32),
        .ghrBits(3),
        .startPc(startPc)
    ) dut_i (
        .clk(clk),
        .reset(reset),
        .pcF_o(pcF),
        .instrF_i(instrF),
        .memWriteM_o(memWriteM),
        .aluResultM_o(aluResultM),
        .writeDataM_o(writeDataM),
        .readDataM_i(readDataM)
    );

    assign instrF    = imem[pcF[9:2]];          // Both memories read combinationally
    assign readDataM = dmem[aluResultM[9:2]];

    // Strobe sampled at the edge that closes its cycle
    always @(posedge clk) begin
        if (!reset && memWriteM) begin
            dmem[aluResultM[9:2]] <= writeDataM;
            storeAddr.push_back(aluResultM);
            storeData.push_back(writeDataM);
        end
    end

    function automatic word_t addiWord(input regAddr_t rd, input regAddr_t rs1, input word_t imm);
        return {imm[11:0], rs1, f3AddSub, rd, opImm};
    endfunction

    function automatic word_t rTypeWord(input logic f7b5, input logic [2:0] f3, input regAddr_t rd,
                                        input regAddr_t rs1, input regAddr_t rs2);
        return {1'b0, f7b5, 5'b0, rs2, rs1, f3, rd, opOp};
    endfunction

    function automatic word_t lwWord(input regAddr_t rd, input regAddr_t rs1, input word_t off);
        return {off[11:0], rs1, f3Word, rd, opLoad};
    endfunction

    function automatic word_t swWord(input regAddr_t rs2, input regAddr_t rs1, input word_t off);
        return {off[11:5], rs2, rs1, f3Word, off[4:0], opStore};
    endfunction

    function automatic word_t branchWord(input logic [2:0] f3, input regAddr_t rs1,
                                         input regAddr_t rs2, input word_t off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], opBranch};
    endfunction

    function automatic word_t jalWord(input regAddr_t rd, input word_t off);
        return {off[20], off[10:1], off[11], off[19:12], rd, opJal};
    endfunction

    function automatic word_t luiWord(input regAddr_t rd, input logic [19:0] imm20);
        return {imm20, rd, opLui};
    endfunction

    function automatic word_t nextRandom(input word_t state);
        return state * 32'd1664525 + 32'd1013904223;   // LCG step
    endfunction

    function automatic word_t fillWord(input word_t addr);
        return {~addr[15:0], addr[15:0]};
    endfunction

    task automatic failRun(input string line);
        $display("%s", line);
        $display("test failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic emit(input word_t instr);
        imem[emitPc[9:2]] = instr;
        emitPc = emitPc + 32'd4;
    endtask

    task automatic expectStore(input word_t addr, input word_t data);
        expAddr.push_back(addr);
        expData.push_back(data);
    endtask

    // Nops everywhere and data memory patterned by address
    task automatic clearMemories();
        for (int i = 0; i < 256; i++) begin
            imem[i] = addiWord(5'd0, 5'd0, 32'd0);
            dmem[i] = fillWord(word_t'(i * 4));
        end
        storeAddr.delete();
        storeData.delete();
        expAddr.delete();
        expData.delete();
        emitPc = startPc;
    endtask

    // Returns once the DUT has seen reset at an edge
    task automatic requestReset();
        int n;
        @(posedge clk);
        #1 resetReq = 1'b1;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!reset && n < 5);
        #1 resetReq = 1'b0;
        assert (reset) else failRun("Timeout: reset did not assert after a request");
    endtask

    task automatic runAndCheck(input string name);
        int n;
        n = 0;
        while (reset && n < timeoutCycles) begin
            @(posedge clk);
            n++;
        end
        assert (!reset) else failRun($sformatf("Timeout: reset never released in %s", name));
        n = 0;
        while (storeAddr.size() < expAddr.size() && n < timeoutCycles) begin
            @(posedge clk);
            n++;
        end
        assert (storeAddr.size() >= expAddr.size())
            else failRun($sformatf("Timeout: %s made only %0d of %0d stores",
                                   name, storeAddr.size(), expAddr.size()));
        repeat (quietCycles) @(posedge clk);
        assert (storeAddr.size() == expAddr.size())
            else failRun($sformatf("Fail at %0d ns: %s made %0d stores, expected %0d",
                                   $time, name, storeAddr.size(), expAddr.size()));
        for (int i = 0; i < expAddr.size(); i++) begin
            assert (storeAddr[i] === expAddr[i] && storeData[i] === expData[i])
                else failRun($sformatf(
                    "Fail at %0d ns: %s store %0d wrote %h to %h, expected %h to %h",
                    $time, name, i, storeData[i], storeAddr[i], expData[i], expAddr[i]));
        end
    endtask

    // Back-to-back dependent ALU ops
    task automatic checkForwarding();
        word_t v [11];
        requestReset();
        clearMemories();
        v[0]  = '0;
        v[1]  = 32'd25;
        v[2]  = v[1] - 32'd7;
        v[3]  = v[1] + v[2];
        v[4]  = v[3] - v[1];
        v[5]  = v[4] & v[3];
        v[6]  = v[5] | v[1];
        v[10] = v[2] - 32'd100;     // Negative so slt must compare signed
        v[7]  = ($signed(v[10]) < $signed(v[3])) ? 32'd1 : 32'd0;
        v[8]  = 32'h12345 << 12;
        v[9]  = v[8] + v[7];
        emit(addiWord(5'd1, 5'd0, 32'd25));
        emit(addiWord(5'd2, 5'd1, -32'sd7));
        emit(rTypeWord(1'b0, f3AddSub, 5'd3, 5'd1, 5'd2));
        emit(rTypeWord(1'b1, f3AddSub, 5'd4, 5'd3, 5'd1));
        emit(rTypeWord(1'b0, f3And, 5'd5, 5'd4, 5'd3));
        emit(rTypeWord(1'b0, f3Or, 5'd6, 5'd5, 5'd1));
        emit(addiWord(5'd10, 5'd2, -32'sd100));
        emit(rTypeWord(1'b0, f3Slt, 5'd7, 5'd10, 5'd3));
        emit(luiWord(5'd8, 20'h12345));
        emit(rTypeWord(1'b0, f3AddSub, 5'd9, 5'd8, 5'd7));
        for (int r = 1; r <= 10; r++) begin
            emit(swWord(regAddr_t'(r), 5'd0, 32'h100 + 4 * r));
            expectStore(32'h100 + 4 * r, v[r]);
        end
        emit(jalWord(5'd0, 32'd0));
        runAndCheck("forwarding");
    endtask

    task automatic loadUseStall();
        word_t preset;
        requestReset();
        clearMemories();
        preset = fillWord(32'h300);
        emit(addiWord(5'd1, 5'd0, 32'd1445));
        emit(addiWord(5'd4, 5'd0, 32'd300));
        emit(swWord(5'd1, 5'd0, 32'h200));
        emit(lwWord(5'd2, 5'd0, 32'h200));
        emit(rTypeWord(1'b0, f3AddSub, 5'd3, 5'd2, 5'd4));   // Uses the load at once
        emit(swWord(5'd3, 5'd0, 32'h204));
        emit(lwWord(5'd5, 5'd0, 32'h300));
        emit(rTypeWord(1'b0, f3AddSub, 5'd6, 5'd5, 5'd5));
        emit(swWord(5'd6, 5'd0, 32'h208));
        emit(jalWord(5'd0, 32'd0));
        expectStore(32'h200, 32'd1445);
        expectStore(32'h204, 32'd1445 + 32'd300);
        expectStore(32'h208, preset + preset);
        runAndCheck("load-use");
    endtask

    // Sum of a count-down with one store at the end
    task automatic countdownLoop();
        int n;
        requestReset();
        clearMemories();
        n = 12;
        emit(addiWord(5'd1, 5'd0, word_t'(n)));
        emit(addiWord(5'd2, 5'd0, 32'd0));
        emit(rTypeWord(1'b0, f3AddSub, 5'd2, 5'd2, 5'd1));
        emit(addiWord(5'd1, 5'd1, -32'sd1));
        emit(branchWord(f3Bne, 5'd1, 5'd0, -32'sd8));
        emit(swWord(5'd2, 5'd0, 32'h280));
        emit(jalWord(5'd0, 32'd0));
        expectStore(32'h280, word_t'(n * (n + 1) / 2));
        runAndCheck("bne loop");
    endtask

    task automatic jumpAndFallThrough();
        word_t linkValue;
        requestReset();
        clearMemories();
        emit(addiWord(5'd1, 5'd0, 32'd7));
        emit(addiWord(5'd2, 5'd0, 32'd9));
        linkValue = emitPc + 32'd4;
        emit(jalWord(5'd5, 32'd8));                     // Over the next store
        emit(swWord(5'd1, 5'd0, 32'h2C0));              // Must never appear
        emit(branchWord(f3Beq, 5'd1, 5'd2, 32'd8));     // Unequal so it falls through
        emit(swWord(5'd2, 5'd0, 32'h2C4));
        emit(swWord(5'd5, 5'd0, 32'h2C8));
        emit(jalWord(5'd0, 32'd0));
        expectStore(32'h2C4, 32'd9);
        expectStore(32'h2C8, linkValue);
        runAndCheck("jumps");
    endtask

    task automatic randomAlu();
        word_t acc;
        word_t last;
        word_t imm;
        word_t addr;
        requestReset();
        clearMemories();
        acc  = '0;      // x1
        last = '0;      // x2
        for (int k = 0; k < 20; k++) begin
            rngState = nextRandom(rngState);
            imm  = {{20{rngState[27]}}, rngState[27:16]};
            addr = 32'h100 + 4 * k;
            if (rngState[31]) begin
                last = acc + imm;
                emit(addiWord(5'd2, 5'd1, imm));
                emit(swWord(5'd2, 5'd0, addr));
                expectStore(addr, last);
            end else begin
                acc = acc + last;
                emit(rTypeWord(1'b0, f3AddSub, 5'd1, 5'd1, 5'd2));
                emit(swWord(5'd1, 5'd0, addr));
                expectStore(addr, acc);
            end
        end
        emit(jalWord(5'd0, 32'd0));
        runAndCheck("random ALU");
    endtask

    // Reset in the middle of a stream of stores
    task automatic resetBehavior();
        int n;
        requestReset();
        clearMemories();
        emit(swWord(5'd0, 5'd0, 32'h100));
        emit(jalWord(5'd0, -32'sd4));
        n = 0;
        while (storeAddr.size() == 0 && n < timeoutCycles) begin
            @(posedge clk);
            n++;
        end
        assert (storeAddr.size() > 0) else failRun("Timeout: the store loop never stored");
        requestReset();
        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (reset) begin
                assert (memWriteM === 1'b0)
                    else failRun($sformatf("Fail at %0d ns: store strobe %b during reset",
                                           $time, memWriteM));
            end
        end while (reset && n < timeoutCycles);
        assert (!reset) else failRun("Timeout: reset was not released");
        assert (pcF === startPc)
            else failRun($sformatf("Fail at %0d ns: first fetch after reset at %h, expected %h",
                                   $time, pcF, startPc));
    endtask

    initial begin
        resetReq = 1'b0;
        rngState = 32'hd6c8_9db1;
        clearMemories();
        checkForwarding();
        loadUseStall();
        countdownLoop();
        jumpAndFallThrough();
        randomAlu();
        resetBehavior();
        $display("test passed");
        $finish;
    end

endmodule

//--- all.f
source/rvPipePkg.sv
source/instrDecoder.sv
source/regFile.sv
source/branchPredictor.sv
source/hazardUnit.sv
source/datapath.sv
source/rvPipeTop.sv
sim/clockGen.sv
sim/rvPipeTb.sv

//--- Bender.yml
package:
  name: rv_pipe

sources:
  - source/rvPipePkg.sv
  - source/instrDecoder.sv
  - source/regFile.sv
  - source/branchPredictor.sv
  - source/hazardUnit.sv
  - source/datapath.sv
  - source/rvPipeTop.sv
  - target: simulation
    files:
      - sim/clockGen.sv
      - sim/rvPipeTb.sv
